/* cache_pkg.sv */
`default_nettype none
//////////////////////////////////////////////////
// Cache definitions.
// Request operation codes, controller sequencing
// states and the default word and block widths.
//////////////////////////////////////////////////

package cache_pkg;

	// Default word width in bits.
	localparam int XLEN_DEFAULT = 64;

	// Default RAM block width in bits, one slow RAM transfer.
	localparam int BLOCK_WIDTH_DEFAULT = 128;

	// Operation on the processor port.
	// None is accepted and dropped without effect.
	typedef enum logic [1:0] {
		op_none  = 2'b00,
		op_load  = 2'b01,
		op_store = 2'b10,
		op_flush = 2'b11
	} cache_op_t;

	// Controller sequencing state.
	// Writing covers a write-back, reading covers a fill.
	typedef enum logic [1:0] {
		state_idle    = 2'b00,
		state_writing = 2'b01,
		state_reading = 2'b10
	} cache_state_t;

endpackage

`default_nettype wire

/* cache_ifs.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Cache internal interfaces.
// Held request, cached line access and the block
// command channel to the slow RAM side.
//////////////////////////////////////////////////

// Held request from the request port to the controller.
interface req_if #(
	parameter int XLEN = cache_pkg::XLEN_DEFAULT
);
	logic                held_valid;
	cache_pkg::cache_op_t held_op;
	logic [XLEN-1:0]     held_address;
	logic [XLEN-1:0]     held_store_value;
	// Single cycle pulse, frees the holding register.
	logic                retire;

	modport source (
		output held_valid, held_op, held_address, held_store_value,
		input  retire
	);

	modport sink (
		input  held_valid, held_op, held_address, held_store_value,
		output retire
	);
endinterface

// Cached line state and its update controls.
interface line_if #(
	parameter int XLEN        = cache_pkg::XLEN_DEFAULT,
	parameter int BLOCK_WIDTH = cache_pkg::BLOCK_WIDTH_DEFAULT
);
	localparam int BLOCK_NUM_W = XLEN - $clog2(BLOCK_WIDTH / 8);

	logic [BLOCK_NUM_W-1:0] tag;
	logic                   valid;
	logic                   dirty;
	logic [BLOCK_WIDTH-1:0] read_block;
	// Writes land at the next edge.
	logic                   write_enable;
	logic [BLOCK_WIDTH-1:0] write_block;
	logic [BLOCK_NUM_W-1:0] write_tag;
	logic                   mark_dirty;
	logic                   mark_clean;

	modport store (
		output tag, valid, dirty, read_block,
		input  write_enable, write_block, write_tag, mark_dirty, mark_clean
	);

	modport controller (
		input  tag, valid, dirty, read_block,
		output write_enable, write_block, write_tag, mark_dirty, mark_clean
	);
endinterface

// Block commands between the controller and the RAM side.
interface ram_if #(
	parameter int XLEN        = cache_pkg::XLEN_DEFAULT,
	parameter int BLOCK_WIDTH = cache_pkg::BLOCK_WIDTH_DEFAULT
);
	localparam int BLOCK_NUM_W = XLEN - $clog2(BLOCK_WIDTH / 8);

	// Start pulses, address and store block are one cycle wide.
	logic                   start_load;
	logic                   start_store;
	logic [BLOCK_NUM_W-1:0] address;
	logic [BLOCK_WIDTH-1:0] store_block;
	// Fill block is valid only while done is high.
	logic                   done;
	logic [BLOCK_WIDTH-1:0] fill_block;

	modport controller (
		output start_load, start_store, address, store_block,
		input  done, fill_block
	);

	modport port (
		input  start_load, start_store, address, store_block,
		output done, fill_block
	);
endinterface

`default_nettype wire

/* request_port.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Request port.
// Accepts one processor request and holds it
// until the controller retires it.
//////////////////////////////////////////////////

module request_port #(
	parameter int XLEN = cache_pkg::XLEN_DEFAULT
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 req_valid,
	input  cache_pkg::cache_op_t req_op,
	input  logic [XLEN-1:0]      req_address,
	input  logic [XLEN-1:0]      req_store_value,
	output logic                 req_ready,
	req_if.source                req
);

	// Holding register state.
	logic                 full;
	logic                 full_next;
	logic                 accept;
	cache_pkg::cache_op_t op_q;
	logic [XLEN-1:0]      address_q;
	logic [XLEN-1:0]      store_value_q;

	// Ready is only high when the holder is empty.
	assign accept = req_valid && req_ready;

	// Accept and retire never meet, one needs empty and one needs full.
	always_comb begin
		full_next = full;
		if (accept) begin
			full_next = 1'b1;
		end else if (req.retire) begin
			full_next = 1'b0;
		end
	end

	// Ready is registered so that it stays low through reset.
	always_ff @(posedge clock) begin
		if (reset) begin
			full      <= 1'b0;
			req_ready <= 1'b0;
		end else begin
			full      <= full_next;
			req_ready <= !full_next;
		end
	end

	// Request payload.
	always_ff @(posedge clock) begin
		if (accept) begin
			op_q          <= req_op;
			address_q     <= req_address;
			store_value_q <= req_store_value;
		end
	end

	assign req.held_valid       = full;
	assign req.held_op          = op_q;
	assign req.held_address     = address_q;
	assign req.held_store_value = store_value_q;

endmodule

`default_nettype wire

/* line_store.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Line store.
// The single cached block with its block number,
// valid bit and dirty bit.
//////////////////////////////////////////////////

module line_store #(
	parameter int XLEN        = cache_pkg::XLEN_DEFAULT,
	parameter int BLOCK_WIDTH = cache_pkg::BLOCK_WIDTH_DEFAULT
) (
	input logic clock,
	input logic reset,
	line_if.store line
);

	// Block number width, address above the block offset.
	localparam int BLOCK_NUM_W = XLEN - $clog2(BLOCK_WIDTH / 8);

	logic [BLOCK_WIDTH-1:0] block_q;
	logic [BLOCK_NUM_W-1:0] tag_q;
	logic                   valid_q;
	logic                   dirty_q;

	// Control bits.
	// Any block write makes the line valid.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			dirty_q <= 1'b0;
		end else begin
			if (line.write_enable) begin
				valid_q <= 1'b1;
			end
			// Dirty wins if both are asked for.
			if (line.mark_dirty) begin
				dirty_q <= 1'b1;
			end else if (line.mark_clean) begin
				dirty_q <= 1'b0;
			end
		end
	end

	// Block data and its number, replaced as a whole.
	always_ff @(posedge clock) begin
		if (line.write_enable) begin
			block_q <= line.write_block;
			tag_q   <= line.write_tag;
		end
	end

	assign line.tag        = tag_q;
	assign line.valid      = valid_q;
	assign line.dirty      = dirty_q;
	assign line.read_block = block_q;

endmodule

`default_nettype wire

/* cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Cache controller.
// Hit or miss decision, write-back and fill
// sequencing, store merge and load response.
//////////////////////////////////////////////////

module cache_controller #(
	parameter int XLEN        = cache_pkg::XLEN_DEFAULT,
	parameter int BLOCK_WIDTH = cache_pkg::BLOCK_WIDTH_DEFAULT
) (
	input  logic            clock,
	input  logic            reset,
	req_if.sink             req,
	line_if.controller      line,
	ram_if.controller       ram,
	output logic            load_valid,
	output logic [XLEN-1:0] load_value
);

	// Address is block number, word index, byte offset.
	localparam int BYTE_OFFSET_W = $clog2(XLEN / 8);
	localparam int WORD_INDEX_W  = $clog2(BLOCK_WIDTH / XLEN);
	localparam int BLOCK_NUM_W   = XLEN - WORD_INDEX_W - BYTE_OFFSET_W;
	localparam int WORD_SHIFT    = $clog2(XLEN);

	cache_pkg::cache_state_t        state;
	cache_pkg::cache_state_t        state_next;
	logic [BLOCK_NUM_W-1:0]         block_num;
	logic [WORD_INDEX_W-1:0]        word_index;
	logic [WORD_INDEX_W+WORD_SHIFT-1:0] word_base;
	logic [XLEN-1:0]                word;
	logic [BLOCK_WIDTH-1:0]         merged_block;
	logic                           hit;
	logic                           load_fire;

	assign block_num  = req.held_address[XLEN-1 -: BLOCK_NUM_W];
	assign word_index = req.held_address[BYTE_OFFSET_W +: WORD_INDEX_W];
	// Bit position of the addressed word in the block.
	assign word_base  = {word_index, {WORD_SHIFT{1'b0}}};
	assign hit        = line.valid && (line.tag == block_num);
	assign word       = line.read_block[word_base +: XLEN];

	// Store word merged into the current block.
	always_comb begin
		merged_block = line.read_block;
		merged_block[word_base +: XLEN] = req.held_store_value;
	end

	always_comb begin
		state_next        = state;
		load_fire         = 1'b0;
		req.retire        = 1'b0;
		line.write_enable = 1'b0;
		line.write_block  = merged_block;
		line.write_tag    = block_num;
		line.mark_dirty   = 1'b0;
		line.mark_clean   = 1'b0;
		ram.start_load    = 1'b0;
		ram.start_store   = 1'b0;
		ram.address       = block_num;
		ram.store_block   = line.read_block;

		case (state)
			cache_pkg::state_idle: begin
				if (req.held_valid) begin
					if (req.held_op == cache_pkg::op_flush) begin
						// Flush only writes back a dirty line.
						if (line.valid && line.dirty) begin
							ram.start_store = 1'b1;
							ram.address     = line.tag;
							state_next      = cache_pkg::state_writing;
						end else begin
							req.retire = 1'b1;
						end
					end else if (req.held_op == cache_pkg::op_none) begin
						req.retire = 1'b1;
					end else if (hit) begin
						req.retire = 1'b1;
						if (req.held_op == cache_pkg::op_store) begin
							line.write_enable = 1'b1;
							line.mark_dirty   = 1'b1;
						end else begin
							load_fire = 1'b1;
						end
					end else if (line.valid && line.dirty) begin
						// Miss on a dirty line, old block goes out first.
						ram.start_store = 1'b1;
						ram.address     = line.tag;
						state_next      = cache_pkg::state_writing;
					end else begin
						ram.start_load = 1'b1;
						state_next     = cache_pkg::state_reading;
					end
				end
			end

			cache_pkg::state_writing: begin
				if (ram.done) begin
					if (req.held_op == cache_pkg::op_flush) begin
						// Flush ends here, no fill.
						line.mark_clean = 1'b1;
						req.retire      = 1'b1;
						state_next      = cache_pkg::state_idle;
					end else begin
						ram.start_load = 1'b1;
						state_next     = cache_pkg::state_reading;
					end
				end
			end

			cache_pkg::state_reading: begin
				// Fill, then the held request hits from idle.
				if (ram.done) begin
					line.write_enable = 1'b1;
					line.write_block  = ram.fill_block;
					line.mark_clean   = 1'b1;
					state_next        = cache_pkg::state_idle;
				end
			end

			default: begin
				state_next = cache_pkg::state_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= cache_pkg::state_idle;
			load_valid <= 1'b0;
		end else begin
			state      <= state_next;
			load_valid <= load_fire;
		end
	end

	// Load word, one cycle after the retire.
	always_ff @(posedge clock) begin
		if (load_fire) begin
			load_value <= word;
		end
	end

endmodule

`default_nettype wire

/* ram_block_port.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// RAM block port.
// Issues slow RAM commands, waits out the busy
// time and hands the fill block back.
//////////////////////////////////////////////////

module ram_block_port #(
	parameter int XLEN        = cache_pkg::XLEN_DEFAULT,
	parameter int BLOCK_WIDTH = cache_pkg::BLOCK_WIDTH_DEFAULT
) (
	input  logic                                    clock,
	input  logic                                    reset,
	ram_if.port                                     ram,
	output logic                                    slow_load,
	output logic                                    slow_store,
	output logic [XLEN-$clog2(BLOCK_WIDTH / 8)-1:0] slow_address,
	output logic [BLOCK_WIDTH-1:0]                  slow_store_value,
	input  logic                                    slow_busy,
	input  logic [BLOCK_WIDTH-1:0]                  slow_load_value
);

	// High from the cycle after a command until it completes.
	logic outstanding;

	// Command strobes, one cycle each.
	always_ff @(posedge clock) begin
		if (reset) begin
			slow_load  <= 1'b0;
			slow_store <= 1'b0;
		end else begin
			slow_load  <= ram.start_load;
			slow_store <= ram.start_store;
		end
	end

	// Command payload.
	always_ff @(posedge clock) begin
		if (ram.start_load || ram.start_store) begin
			slow_address <= ram.address;
		end
		if (ram.start_store) begin
			slow_store_value <= ram.store_block;
		end
	end

	// The command cycle itself never completes.
	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= 1'b0;
		end else if (slow_load || slow_store) begin
			outstanding <= 1'b1;
		end else if (ram.done) begin
			outstanding <= 1'b0;
		end
	end

	// First cycle after the command with busy low.
	assign ram.done = outstanding && !slow_busy;

	// RAM data is valid in the completing cycle.
	// The line store takes it at the edge.
	assign ram.fill_block = slow_load_value;

endmodule

`default_nettype wire

/* ram_cache.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Single block write-back cache.
// Sits between a load/store port and a slow
// block-wide RAM.
//////////////////////////////////////////////////

module ram_cache #(
	parameter int XLEN        = cache_pkg::XLEN_DEFAULT,
	parameter int BLOCK_WIDTH = cache_pkg::BLOCK_WIDTH_DEFAULT
) (
	input  logic                                    clock,
	input  logic                                    reset,
	// Processor side.
	input  logic                                    req_valid,
	input  cache_pkg::cache_op_t                    req_op,
	input  logic [XLEN-1:0]                         req_address,
	input  logic [XLEN-1:0]                         req_store_value,
	output logic                                    req_ready,
	output logic                                    load_valid,
	output logic [XLEN-1:0]                         load_value,
	// Slow RAM side.
	output logic                                    slow_load,
	output logic                                    slow_store,
	output logic [XLEN-$clog2(BLOCK_WIDTH / 8)-1:0] slow_address,
	output logic [BLOCK_WIDTH-1:0]                  slow_store_value,
	input  logic                                    slow_busy,
	input  logic [BLOCK_WIDTH-1:0]                  slow_load_value
);

	req_if  #(.XLEN(XLEN))                           req_bus ();
	line_if #(.XLEN(XLEN), .BLOCK_WIDTH(BLOCK_WIDTH)) line_bus ();
	ram_if  #(.XLEN(XLEN), .BLOCK_WIDTH(BLOCK_WIDTH)) ram_bus ();

	request_port #(.XLEN(XLEN)) u_request_port (
		.clock           (clock),
		.reset           (reset),
		.req_valid       (req_valid),
		.req_op          (req_op),
		.req_address     (req_address),
		.req_store_value (req_store_value),
		.req_ready       (req_ready),
		.req             (req_bus.source)
	);

	cache_controller #(.XLEN(XLEN), .BLOCK_WIDTH(BLOCK_WIDTH)) u_cache_controller (
		.clock      (clock),
		.reset      (reset),
		.req        (req_bus.sink),
		.line       (line_bus.controller),
		.ram        (ram_bus.controller),
		.load_valid (load_valid),
		.load_value (load_value)
	);

	line_store #(.XLEN(XLEN), .BLOCK_WIDTH(BLOCK_WIDTH)) u_line_store (
		.clock (clock),
		.reset (reset),
		.line  (line_bus.store)
	);

	ram_block_port #(.XLEN(XLEN), .BLOCK_WIDTH(BLOCK_WIDTH)) u_ram_block_port (
		.clock            (clock),
		.reset            (reset),
		.ram              (ram_bus.port),
		.slow_load        (slow_load),
		.slow_store       (slow_store),
		.slow_address     (slow_address),
		.slow_store_value (slow_store_value),
		.slow_busy        (slow_busy),
		.slow_load_value  (slow_load_value)
	);

endmodule

`default_nettype wire

/* ram_cache_chk.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Cache protocol assertions.
// Bound into the controller and the RAM port.
//////////////////////////////////////////////////

module ram_cache_chk (
	input logic                    clock,
	input logic                    reset,
	input cache_pkg::cache_state_t state,
	input logic                    load_valid,
	input logic                    slow_load,
	input logic                    slow_store,
	input logic                    outstanding
);

	// One command strobe at a time.
	single_command: assert property (@(posedge clock) disable iff (reset)
		!(slow_load && slow_store))
		else $error("slow_load and slow_store are high together");

	// A new command waits for the previous one to complete.
	no_overlap: assert property (@(posedge clock) disable iff (reset)
		(slow_load || slow_store) |-> !outstanding)
		else $error("slow command issued while another is outstanding");

	// Load responses come only from a hit in idle.
	load_in_idle: assert property (@(posedge clock) disable iff (reset)
		$rose(load_valid) |-> (state == cache_pkg::state_idle))
		else $error("load_valid rose outside the idle state");

endmodule

bind cache_controller ram_cache_chk u_controller_chk (
	.clock       (clock),
	.reset       (reset),
	.state       (state),
	.load_valid  (load_valid),
	.slow_load   (1'b0),
	.slow_store  (1'b0),
	.outstanding (1'b0)
);

bind ram_block_port ram_cache_chk u_port_chk (
	.clock       (clock),
	.reset       (reset),
	.state       (cache_pkg::state_idle),
	.load_valid  (1'b0),
	.slow_load   (slow_load),
	.slow_store  (slow_store),
	.outstanding (outstanding)
);

`default_nettype wire

/* tb_ram_model.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Slow block RAM model.
// Backing array with a random busy time per
// command, and a record of every command.
//////////////////////////////////////////////////

module tb_ram_model #(
	parameter int XLEN        = cache_pkg::XLEN_DEFAULT,
	parameter int BLOCK_WIDTH = cache_pkg::BLOCK_WIDTH_DEFAULT
) (
	input  logic                                    clock,
	input  logic                                    reset,
	input  logic                                    slow_load,
	input  logic                                    slow_store,
	input  logic [XLEN-$clog2(BLOCK_WIDTH / 8)-1:0] slow_address,
	input  logic [BLOCK_WIDTH-1:0]                  slow_store_value,
	output logic                                    slow_busy,
	output logic [BLOCK_WIDTH-1:0]                  slow_load_value
);

	localparam int BLOCK_NUM_W = XLEN - $clog2(BLOCK_WIDTH / 8);
	localparam int WORDS       = BLOCK_WIDTH / XLEN;

	integer                 seed = 32'h7b4;
	int                     busy_left = 0;
	int                     busy_length;
	logic                   busy_q = 1'b0;
	logic [BLOCK_WIDTH-1:0] value_q = '0;
	// Written blocks only, unwritten blocks read as the fill pattern.
	logic [BLOCK_WIDTH-1:0] mem [logic [BLOCK_NUM_W-1:0]];
	// Command record.
	logic [BLOCK_NUM_W-1:0] store_address_q [$];
	logic [BLOCK_WIDTH-1:0] store_block_q [$];
	logic [BLOCK_NUM_W-1:0] load_address_q [$];

	// Current content of one block.
	function automatic logic [BLOCK_WIDTH-1:0] backing_block(logic [BLOCK_NUM_W-1:0] address);
		logic [BLOCK_WIDTH-1:0] blk;
		logic [XLEN-1:0]        word_address;
		if (mem.exists(address)) begin
			return mem[address];
		end
		// Each word is its own word address scrambled by a constant.
		for (int i = 0; i < WORDS; i++) begin
			word_address = XLEN'(address) * WORDS + XLEN'(i);
			blk[i*XLEN +: XLEN] = word_address ^ XLEN'(64'h9e37_79b9_7f4a_7c15);
		end
		return blk;
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			busy_q    <= 1'b0;
			busy_left <= 0;
		end else if (slow_load || slow_store) begin
			// Busy for 0 to 3 cycles after the command.
			busy_length = int'($unsigned($random(seed)) % 4);
			busy_left <= busy_length;
			busy_q    <= (busy_length != 0);
			if (slow_store) begin
				mem[slow_address] = slow_store_value;
				store_address_q.push_back(slow_address);
				store_block_q.push_back(slow_store_value);
			end
			if (slow_load) begin
				value_q <= backing_block(slow_address);
				load_address_q.push_back(slow_address);
			end
		end else if (busy_left != 0) begin
			busy_left <= busy_left - 1;
			busy_q    <= (busy_left > 1);
		end
	end

	assign slow_busy       = busy_q;
	assign slow_load_value = value_q;

endmodule

`default_nettype wire

/* tb_ram_cache.sv */
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////
// Testbench for the single block cache.
// Directed tests checked against a shadow word
// memory and a predicted line state.
//////////////////////////////////////////////////

module tb_ram_cache;

	localparam int XLEN          = cache_pkg::XLEN_DEFAULT;
	localparam int BLOCK_WIDTH   = cache_pkg::BLOCK_WIDTH_DEFAULT;
	localparam int BYTE_OFFSET_W = $clog2(XLEN / 8);
	localparam int WORD_INDEX_W  = $clog2(BLOCK_WIDTH / XLEN);
	localparam int BLOCK_NUM_W   = XLEN - WORD_INDEX_W - BYTE_OFFSET_W;
	localparam int WORDS         = BLOCK_WIDTH / XLEN;
	localparam int TIMEOUT       = 100;

	typedef logic [XLEN-1:0]               word_t;
	typedef logic [BLOCK_WIDTH-1:0]        block_t;
	typedef logic [BLOCK_NUM_W-1:0]        block_num_t;
	typedef logic [WORD_INDEX_W-1:0]       word_index_t;
	typedef logic [XLEN-BYTE_OFFSET_W-1:0] word_addr_t;

	logic                 clock;
	logic                 reset;
	logic                 req_valid;
	cache_pkg::cache_op_t req_op;
	word_t                req_address;
	word_t                req_store_value;
	logic                 req_ready;
	logic                 load_valid;
	word_t                load_value;
	logic                 slow_load;
	logic                 slow_store;
	block_num_t           slow_address;
	block_t               slow_store_value;
	logic                 slow_busy;
	block_t               slow_load_value;

	integer     seed = 32'h7b4;
	int         error_count = 0;
	int         test_count = 0;
	int         failed_tests = 0;
	// Expected memory contents by word address.
	word_t      shadow [word_addr_t];
	// Predicted line state.
	block_num_t line_tag = '0;
	logic       line_valid = 1'b0;
	logic       line_dirty = 1'b0;

	ram_cache #(.XLEN(XLEN), .BLOCK_WIDTH(BLOCK_WIDTH)) u_dut (
		.clock            (clock),
		.reset            (reset),
		.req_valid        (req_valid),
		.req_op           (req_op),
		.req_address      (req_address),
		.req_store_value  (req_store_value),
		.req_ready        (req_ready),
		.load_valid       (load_valid),
		.load_value       (load_value),
		.slow_load        (slow_load),
		.slow_store       (slow_store),
		.slow_address     (slow_address),
		.slow_store_value (slow_store_value),
		.slow_busy        (slow_busy),
		.slow_load_value  (slow_load_value)
	);

	tb_ram_model #(.XLEN(XLEN), .BLOCK_WIDTH(BLOCK_WIDTH)) u_ram_model (
		.clock            (clock),
		.reset            (reset),
		.slow_load        (slow_load),
		.slow_store       (slow_store),
		.slow_address     (slow_address),
		.slow_store_value (slow_store_value),
		.slow_busy        (slow_busy),
		.slow_load_value  (slow_load_value)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Unwritten words hold their word address scrambled by a constant.
	function automatic word_t initial_word(word_addr_t wa);
		return word_t'(wa) ^ word_t'(64'h9e37_79b9_7f4a_7c15);
	endfunction

	function automatic word_t shadow_word(word_addr_t wa);
		if (shadow.exists(wa)) begin
			return shadow[wa];
		end
		return initial_word(wa);
	endfunction

	function automatic block_t shadow_block(block_num_t blk_num);
		block_t blk;
		for (int i = 0; i < WORDS; i++) begin
			blk[i*XLEN +: XLEN] = shadow_word({blk_num, word_index_t'(i)});
		end
		return blk;
	endfunction

	function automatic word_t make_address(block_num_t blk_num, word_index_t index);
		return {blk_num, index, {BYTE_OFFSET_W{1'b0}}};
	endfunction

	task automatic check_word(string name, word_t got, word_t expected);
		if (got !== expected) begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_block(string name, block_num_t got_address, block_num_t exp_address,
			block_t got, block_t expected);
		if (got_address !== exp_address) begin
			$display("Fail %s address: got 0x%h expected 0x%h", name, got_address, exp_address);
			error_count++;
		end
		if (got !== expected) begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_count(string name, int got, int expected);
		if (got != expected) begin
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, expected);
			error_count++;
		end
	endtask

	// Inputs change 1 ns after the rising edge.
	// Outputs are sampled at the same point.
	task automatic step();
		@(posedge clock);
		#1;
	endtask

	// Hands one request over and waits until req_ready returns.
	task automatic run_request(cache_pkg::cache_op_t op, word_t address, word_t value,
			output word_t loaded, output int pulses);
		int   cycles;
		logic accepted;
		logic finished;
		loaded          = '0;
		pulses          = 0;
		req_valid       = 1'b1;
		req_op          = op;
		req_address     = address;
		req_store_value = value;
		accepted        = 1'b0;
		cycles          = 0;
		while (!accepted && cycles < TIMEOUT) begin
			accepted = req_ready;
			step();
			cycles++;
		end
		req_valid = 1'b0;
		req_op    = cache_pkg::op_none;
		if (!accepted) begin
			$display("Request was not accepted within %0d cycles", TIMEOUT);
			error_count++;
		end else begin
			finished = 1'b0;
			cycles   = 0;
			while (!finished && cycles < TIMEOUT) begin
				if (load_valid) begin
					pulses++;
					loaded = load_value;
				end
				if (req_ready) begin
					finished = 1'b1;
				end else begin
					step();
					cycles++;
				end
			end
			if (!finished) begin
				$display("Request did not complete within %0d cycles", TIMEOUT);
				error_count++;
			end
		end
	endtask

	// Predicts the slow commands and the load word.
	// Then runs the request and checks both.
	task automatic checked_request(cache_pkg::cache_op_t op, word_t address, word_t value);
		block_num_t blk_num;
		word_addr_t wa;
		block_num_t old_tag;
		block_t     old_block;
		int         stores_before;
		int         loads_before;
		int         exp_stores;
		int         exp_loads;
		int         pulses;
		word_t      loaded;
		blk_num       = address[XLEN-1 -: BLOCK_NUM_W];
		wa            = address[XLEN-1:BYTE_OFFSET_W];
		old_tag       = line_tag;
		old_block     = shadow_block(line_tag);
		stores_before = u_ram_model.store_address_q.size();
		loads_before  = u_ram_model.load_address_q.size();
		exp_stores    = 0;
		exp_loads     = 0;
		if (op == cache_pkg::op_flush) begin
			exp_stores = (line_valid && line_dirty) ? 1 : 0;
			line_dirty = 1'b0;
		end else if (!(line_valid && line_tag == blk_num)) begin
			// On a miss a dirty line goes out before the fill.
			exp_stores = (line_valid && line_dirty) ? 1 : 0;
			exp_loads  = 1;
			line_valid = 1'b1;
			line_tag   = blk_num;
			line_dirty = 1'b0;
		end
		if (op == cache_pkg::op_store) begin
			line_dirty = 1'b1;
		end
		run_request(op, address, value, loaded, pulses);
		check_count("slow_store count", u_ram_model.store_address_q.size() - stores_before,
			exp_stores);
		check_count("slow_load count", u_ram_model.load_address_q.size() - loads_before,
			exp_loads);
		if (exp_stores == 1 && u_ram_model.store_address_q.size() > stores_before) begin
			check_block("slow_store_value", u_ram_model.store_address_q[stores_before],
				old_tag, u_ram_model.store_block_q[stores_before], old_block);
		end
		if (exp_loads == 1 && u_ram_model.load_address_q.size() > loads_before) begin
			check_word("slow_address", word_t'(u_ram_model.load_address_q[loads_before]),
				word_t'(blk_num));
		end
		check_count("load_valid pulses", pulses, (op == cache_pkg::op_load) ? 1 : 0);
		if (op == cache_pkg::op_load && pulses == 1) begin
			check_word("load_value", loaded, shadow_word(wa));
		end
		if (op == cache_pkg::op_store) begin
			shadow[wa] = value;
		end
	endtask

	task automatic finish_test(string name, int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d %s: passed", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed", test_count, name);
		end
	endtask

	task automatic first_load_miss();
		int errors_before;
		errors_before = error_count;
		checked_request(cache_pkg::op_load, make_address(block_num_t'(5), '0), '0);
		finish_test("first load miss", errors_before);
	endtask

	task automatic hit_loads();
		int errors_before;
		errors_before = error_count;
		checked_request(cache_pkg::op_load, make_address(block_num_t'(5), '0), '0);
		checked_request(cache_pkg::op_load,
			make_address(block_num_t'(5), word_index_t'(WORDS - 1)), '0);
		finish_test("hit loads", errors_before);
	endtask

	task automatic store_hit_then_load();
		int    errors_before;
		word_t address;
		errors_before = error_count;
		address       = make_address(block_num_t'(5), word_index_t'(WORDS - 1));
		checked_request(cache_pkg::op_store, address, word_t'(64'h0123_4567_89ab_cdef));
		checked_request(cache_pkg::op_load, address, '0);
		finish_test("store hit then load", errors_before);
	endtask

	task automatic dirty_miss_write_back();
		int errors_before;
		errors_before = error_count;
		checked_request(cache_pkg::op_load, make_address(block_num_t'(9), '0), '0);
		finish_test("dirty miss write-back", errors_before);
	endtask

	task automatic flush_dirty_block();
		int errors_before;
		errors_before = error_count;
		checked_request(cache_pkg::op_store, make_address(block_num_t'(9), '0),
			word_t'(64'hfeed_face_cafe_f00d));
		checked_request(cache_pkg::op_flush, '0, '0);
		checked_request(cache_pkg::op_flush, '0, '0);
		// Ready must stay high while the port is idle.
		step();
		check_count("req_ready", int'(req_ready), 1);
		finish_test("flush dirty block", errors_before);
	endtask

	// Random loads and stores over four blocks.
	// A final flush and a memory compare follow.
	task automatic mixed_random_sequence();
		int          errors_before;
		logic [31:0] r;
		block_num_t  blk_num;
		word_t       value;
		block_t      backing;
		errors_before = error_count;
		for (int n = 0; n < 20; n++) begin
			r       = $random(seed);
			blk_num = block_num_t'(64) + block_num_t'(r[1:0]);
			value   = word_t'({$random(seed), $random(seed)});
			checked_request(r[4] ? cache_pkg::op_store : cache_pkg::op_load,
				make_address(blk_num, word_index_t'(r[8 +: WORD_INDEX_W])), value);
		end
		checked_request(cache_pkg::op_flush, '0, '0);
		for (int b = 0; b < 4; b++) begin
			blk_num = block_num_t'(64 + b);
			backing = u_ram_model.backing_block(blk_num);
			for (int i = 0; i < WORDS; i++) begin
				check_word("backing word", backing[i*XLEN +: XLEN],
					shadow_word({blk_num, word_index_t'(i)}));
			end
		end
		finish_test("mixed random sequence", errors_before);
	endtask

	initial begin
		req_valid       = 1'b0;
		req_op          = cache_pkg::op_none;
		req_address     = '0;
		req_store_value = '0;
		reset           = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		first_load_miss();
		hit_loads();
		store_hit_then_load();
		dirty_miss_write_back();
		flush_dirty_block();
		mixed_random_sequence();
		$display("tests run %0d, tests failed %0d, checks failed %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
cache_pkg.sv
cache_ifs.sv
request_port.sv
line_store.sv
cache_controller.sv
ram_block_port.sv
ram_cache.sv
ram_cache_chk.sv
tb_ram_model.sv
tb_ram_cache.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ram_cache -Mdir obj_dir -o sim -f all.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0
